//--- hw/fm_geom_pkg.sv
`default_nettype none

// half-precision word layout shared by the datapath
package fm_geom_pkg;

	localparam int FP16_W     = 16;
	localparam int FP16_EXP_W = 5;
	localparam int FP16_MAN_W = 10;

	// all-ones exponent, inf/nan code space
	localparam logic [FP16_EXP_W-1:0] FP16_EXP_MAX = '1;

	typedef struct packed {
		logic                  sign;
		logic [FP16_EXP_W-1:0] exp;
		logic [FP16_MAN_W-1:0] man;
	} fp16_t;

	localparam fp16_t FP16_ZERO = '0;

	// saturation codes on overflow
	localparam fp16_t FP16_INF_POS = '{sign: 1'b0, exp: FP16_EXP_MAX, man: '0};
	localparam fp16_t FP16_INF_NEG = '{sign: 1'b1, exp: FP16_EXP_MAX, man: '0};

endpackage

`default_nettype wire

//--- hw/fm_ctrl_pkg.sv
`default_nettype none

// control encodings for the write path
package fm_ctrl_pkg;

	// ena_add_write level decoded as opcode
	typedef enum logic {
		WR_STORE = 1'b0, // overwrite the tile
		WR_ADD   = 1'b1  // add tile onto stored words
	} wr_mode_t;

	typedef enum logic {
		ACC_IDLE      = 1'b0,
		ACC_WRITEBACK = 1'b1 // old tile fetched, sums go out
	} acc_state_t;

endpackage

`default_nettype wire

//--- hw/fm_port_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fm_port_if
	import fm_geom_pkg::*;
#(
	parameter int PARA_X  = 3,
	parameter int PARA_Y  = 3,
	parameter int RAM_MAX = 22
) ();
	localparam int TILE_W  = PARA_X * PARA_Y;
	localparam int N_TILES = (RAM_MAX + TILE_W - 1) / TILE_W;
	localparam int WA_W    = (N_TILES > 1) ? $clog2(N_TILES) : 1;

	logic               we;
	logic [WA_W-1:0]    waddr;      // tile index
	fp16_t [0:TILE_W-1] wdata;      // lane 0 in the top word
	logic [WA_W-1:0]    fetch_addr; // tile index
	fp16_t [0:TILE_W-1] fetch_data; // one cycle after fetch_addr

	modport acc (output we, waddr, wdata, fetch_addr, input fetch_data);
	modport store (input we, waddr, wdata, fetch_addr, output fetch_data);

endinterface

`default_nettype wire

//--- hw/fp16_adder.sv
`timescale 1ns/1ps
`default_nettype none

module fp16_adder
	import fm_geom_pkg::*;
(
	input  fp16_t a,
	input  fp16_t b,
	output fp16_t sum
);
	// hidden bit, mantissa, guard, round, sticky
	localparam int SIG_W = FP16_MAN_W + 4;

	fp16_t                big;
	fp16_t                little;
	logic [SIG_W-1:0]     sig_big;
	logic [SIG_W-1:0]     sig_little;
	logic [SIG_W-1:0]     sig_align;
	logic [2*SIG_W-1:0]   shift_buf;
	logic [SIG_W:0]       raw;
	logic [SIG_W-1:0]     norm;
	logic [FP16_MAN_W:0]  man_rnd;
	logic                 sub_op;
	logic                 round_up;
	int                   exp_diff;
	int                   lz;
	int                   exp_res;

	always_comb begin
		// larger magnitude first so the difference never goes negative
		if (a[FP16_W-2:0] >= b[FP16_W-2:0]) begin
			big    = a;
			little = b;
		end else begin
			big    = b;
			little = a;
		end
		sub_op = big.sign ^ little.sign;

		// subnormal inputs count as zero
		sig_big    = (big.exp != '0) ? {1'b1, big.man, 3'b000} : '0;
		sig_little = (little.exp != '0) ? {1'b1, little.man, 3'b000} : '0;

		exp_diff = int'(big.exp) - int'(little.exp);
		if (exp_diff > SIG_W)
			exp_diff = SIG_W; // whole operand lands in sticky

		shift_buf = {sig_little, {SIG_W{1'b0}}} >> exp_diff;
		sig_align = shift_buf[2*SIG_W-1:SIG_W];
		sig_align[0] = sig_align[0] | (|shift_buf[SIG_W-1:0]);

		if (sub_op)
			raw = {1'b0, sig_big} - {1'b0, sig_align};
		else
			raw = {1'b0, sig_big} + {1'b0, sig_align};

		// leading zeros below the carry position
		lz = 0;
		for (int i = 0; i < SIG_W; i++) begin
			if (raw[i])
				lz = SIG_W - 1 - i;
		end

		if (raw[SIG_W]) begin
			// carry out shifts right and keeps sticky
			norm = raw[SIG_W:1];
			norm[0] = raw[1] | raw[0];
			exp_res = int'(big.exp) + 1;
		end else begin
			norm = raw[SIG_W-1:0] << lz;
			exp_res = int'(big.exp) - lz;
		end

		// nearest even on guard/round/sticky
		round_up = norm[2] & (norm[1] | norm[0] | norm[3]);
		man_rnd = {1'b0, norm[SIG_W-2:3]} + {{FP16_MAN_W{1'b0}}, round_up};
		if (man_rnd[FP16_MAN_W])
			exp_res = exp_res + 1; // 1.11..1 rounded up to 10.0

		sum.sign = big.sign;
		sum.exp  = exp_res[FP16_EXP_W-1:0];
		sum.man  = man_rnd[FP16_MAN_W-1:0];

		if (raw == '0) begin
			// -0 only when both inputs are negative zero
			sum.sign = big.sign & little.sign;
			sum.exp  = '0;
			sum.man  = '0;
		end else if (exp_res >= int'(FP16_EXP_MAX)) begin
			sum = big.sign ? FP16_INF_NEG : FP16_INF_POS;
		end else if (exp_res <= 0) begin
			sum.exp = '0; // flush to signed zero
			sum.man = '0;
		end
	end

endmodule

`default_nettype wire

//--- hw/fm_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module fm_accumulator
	import fm_geom_pkg::*;
	import fm_ctrl_pkg::*;
#(
	parameter int PARA_X  = 3,
	parameter int PARA_Y  = 3,
	parameter int RAM_MAX = 22,
	localparam int TILE_W  = PARA_X * PARA_Y,
	localparam int N_TILES = (RAM_MAX + TILE_W - 1) / TILE_W,
	localparam int WA_W    = (N_TILES > 1) ? $clog2(N_TILES) : 1
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     ena_wr,
	input  logic                     ena_add_write,
	input  logic [WA_W-1:0]          addr_write,
	input  logic [TILE_W*FP16_W-1:0] din,
	output logic                     write_ready,
	fm_port_if.acc                   mem
);
	acc_state_t         state;
	wr_mode_t           mode;
	logic               take;
	logic               store_go;
	logic               add_go;
	logic [WA_W-1:0]    add_addr;
	fp16_t [0:TILE_W-1] tile_in;
	fp16_t [0:TILE_W-1] add_tile;
	fp16_t [0:TILE_W-1] lane_sum;

	assign tile_in = din;
	assign mode    = wr_mode_t'(ena_add_write);

	// busy during write-back, ena_wr ignored then
	assign write_ready = (state == ACC_IDLE);
	assign take        = ena_wr & write_ready;
	assign store_go    = take & (mode == WR_STORE);
	assign add_go      = take & (mode == WR_ADD);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ACC_IDLE;
		end else begin
			case (state)
				ACC_IDLE:      if (add_go) state <= ACC_WRITEBACK;
				ACC_WRITEBACK: state <= ACC_IDLE; // one cycle only
				default:       state <= ACC_IDLE;
			endcase
		end
	end

	// operands held for the write-back cycle
	always_ff @(posedge clk) begin
		if (add_go) begin
			add_addr <= addr_write;
			add_tile <= tile_in;
		end
	end

	// old tile arrives from the store one edge later
	assign mem.fetch_addr = addr_write;

	for (genvar k = 0; k < TILE_W; k++) begin : g_lane
		fp16_adder u_add (
			.a  (add_tile[k]),
			.b  (mem.fetch_data[k]),
			.sum(lane_sum[k])
		);
	end

	always_comb begin
		mem.we    = store_go;
		mem.waddr = addr_write;
		mem.wdata = tile_in;
		if (state == ACC_WRITEBACK) begin
			mem.we    = 1'b1;
			mem.waddr = add_addr;
			mem.wdata = lane_sum;
		end
	end

endmodule

`default_nettype wire

//--- hw/fm_read_port.sv
`timescale 1ns/1ps
`default_nettype none

module fm_read_port
	import fm_geom_pkg::*;
#(
	parameter int PARA_Y  = 3,
	parameter int RAM_MAX = 22,
	localparam int N_SLICES = (RAM_MAX + PARA_Y - 1) / PARA_Y,
	localparam int RA_W     = (N_SLICES > 1) ? $clog2(N_SLICES) : 1,
	localparam int WI_W     = $clog2(RAM_MAX + 1)
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     ena_wr,
	input  logic [RA_W-1:0]          addr_read,
	output logic [WI_W-1:0]          raddr,
	input  logic [PARA_Y*FP16_W-1:0] rdata,
	output logic [PARA_Y*FP16_W-1:0] dout
);
	int base;

	// slice index to first word, parked at RAM_MAX when past the end
	always_comb begin
		base = int'(addr_read) * PARA_Y;
		if (base < RAM_MAX)
			raddr = WI_W'(base);
		else
			raddr = WI_W'(RAM_MAX);
	end

	always_ff @(posedge clk) begin
		if (reset)
			dout <= '0;
		else if (!ena_wr)
			dout <= rdata; // held until the next read
	end

endmodule

`default_nettype wire

//--- hw/fm_word_store.sv
`timescale 1ns/1ps
`default_nettype none

module fm_word_store
	import fm_geom_pkg::*;
#(
	parameter int PARA_X  = 3,
	parameter int PARA_Y  = 3,
	parameter int RAM_MAX = 22,
	localparam int TILE_W = PARA_X * PARA_Y,
	localparam int WI_W   = $clog2(RAM_MAX + 1)
) (
	input  logic                     clk,
	input  logic                     reset,
	fm_port_if.store                 mem,
	input  logic [WI_W-1:0]          raddr,
	output logic [PARA_Y*FP16_W-1:0] rdata
);
	fp16_t              words [RAM_MAX];
	fp16_t [0:PARA_Y-1] slice;

	// tile write, lanes past the end are dropped
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < RAM_MAX; i++)
				words[i] <= FP16_ZERO;
		end else if (mem.we) begin
			for (int k = 0; k < TILE_W; k++) begin
				if (int'(mem.waddr) * TILE_W + k < RAM_MAX)
					words[int'(mem.waddr) * TILE_W + k] <= mem.wdata[k];
			end
		end
	end

	// registered tile fetch for the accumulate path
	always_ff @(posedge clk) begin
		for (int k = 0; k < TILE_W; k++) begin
			if (int'(mem.fetch_addr) * TILE_W + k < RAM_MAX)
				mem.fetch_data[k] <= words[int'(mem.fetch_addr) * TILE_W + k];
			else
				mem.fetch_data[k] <= FP16_ZERO;
		end
	end

	// combinational slice, lowest word on top
	always_comb begin
		for (int k = 0; k < PARA_Y; k++) begin
			if (int'(raddr) + k < RAM_MAX)
				slice[k] = words[int'(raddr) + k];
			else
				slice[k] = FP16_ZERO;
		end
	end

	assign rdata = slice;

endmodule

`default_nettype wire

//--- hw/feature_map_ram.sv
`timescale 1ns/1ps
`default_nettype none

module feature_map_ram
	import fm_geom_pkg::*;
#(
	parameter int PARA_X  = 3,  // MAC groups
	parameter int PARA_Y  = 3,  // lanes per group
	parameter int RAM_MAX = 22, // words
	localparam int TILE_W   = PARA_X * PARA_Y,
	localparam int N_TILES  = (RAM_MAX + TILE_W - 1) / TILE_W,
	localparam int WA_W     = (N_TILES > 1) ? $clog2(N_TILES) : 1,
	localparam int N_SLICES = (RAM_MAX + PARA_Y - 1) / PARA_Y,
	localparam int RA_W     = (N_SLICES > 1) ? $clog2(N_SLICES) : 1,
	localparam int WI_W     = $clog2(RAM_MAX + 1)
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     ena_wr,        // 1 write, 0 read
	input  logic                     ena_add_write, // 1 accumulate
	input  logic [WA_W-1:0]          addr_write,
	input  logic [TILE_W*FP16_W-1:0] din,
	input  logic [RA_W-1:0]          addr_read,
	output logic                     write_ready,
	output logic [PARA_Y*FP16_W-1:0] dout
);
	logic [WI_W-1:0]          raddr;
	logic [PARA_Y*FP16_W-1:0] rdata;

	fm_port_if #(
		.PARA_X (PARA_X),
		.PARA_Y (PARA_Y),
		.RAM_MAX(RAM_MAX)
	) u_port ();

	fm_accumulator #(
		.PARA_X (PARA_X),
		.PARA_Y (PARA_Y),
		.RAM_MAX(RAM_MAX)
	) u_acc (
		.clk          (clk),
		.reset        (reset),
		.ena_wr       (ena_wr),
		.ena_add_write(ena_add_write),
		.addr_write   (addr_write),
		.din          (din),
		.write_ready  (write_ready),
		.mem          (u_port.acc)
	);

	fm_read_port #(
		.PARA_Y (PARA_Y),
		.RAM_MAX(RAM_MAX)
	) u_rd (
		.clk      (clk),
		.reset    (reset),
		.ena_wr   (ena_wr),
		.addr_read(addr_read),
		.raddr    (raddr),
		.rdata    (rdata),
		.dout     (dout)
	);

	fm_word_store #(
		.PARA_X (PARA_X),
		.PARA_Y (PARA_Y),
		.RAM_MAX(RAM_MAX)
	) u_store (
		.clk  (clk),
		.reset(reset),
		.mem  (u_port.store),
		.raddr(raddr),
		.rdata(rdata)
	);

endmodule

`default_nettype wire

//--- dv/feature_map_ram_tb.sv
`timescale 1ns/1ps
`default_nettype none

module feature_map_ram_tb
	import fm_geom_pkg::*;
	import fm_ctrl_pkg::*;
();
	localparam int PARA_X        = 3;
	localparam int PARA_Y        = 3;
	localparam int RAM_MAX       = 22;
	localparam int TILE_W        = PARA_X * PARA_Y;
	localparam int N_TILES       = (RAM_MAX + TILE_W - 1) / TILE_W;
	localparam int WA_W          = (N_TILES > 1) ? $clog2(N_TILES) : 1;
	localparam int N_SLICES      = (RAM_MAX + PARA_Y - 1) / PARA_Y;
	localparam int RA_W          = (N_SLICES > 1) ? $clog2(N_SLICES) : 1;
	localparam int CLK_PERIOD    = 8;
	localparam int STIM_DELAY    = 1;
	localparam int RESET_CYCLES  = 10;
	localparam int READY_TIMEOUT = 16;
	localparam int MIX_CYCLES    = 2000;
	localparam logic [31:0] LFSR_SEED = 32'h5619cf72;
	localparam logic [31:0] LFSR_TAPS = 32'h80200003; // x^32 + x^22 + x^2 + x + 1

	typedef fp16_t [0:PARA_Y-1] slice_t;
	typedef fp16_t [0:TILE_W-1] tile_t;

	logic                     clk;
	logic                     reset;
	logic                     ena_wr;
	logic                     ena_add_write;
	logic [WA_W-1:0]          addr_write;
	logic [TILE_W*FP16_W-1:0] din;
	logic [RA_W-1:0]          addr_read;
	logic                     write_ready;
	logic [PARA_Y*FP16_W-1:0] dout;

	logic        rd_check;       // read in this cycle gets compared
	fp16_t       shadow [RAM_MAX];
	slice_t      exp_q [$];
	string       name_q [$];
	logic [31:0] lfsr;
	int          cycles;

	feature_map_ram #(
		.PARA_X (PARA_X),
		.PARA_Y (PARA_Y),
		.RAM_MAX(RAM_MAX)
	) dut (
		.clk          (clk),
		.reset        (reset),
		.ena_wr       (ena_wr),
		.ena_add_write(ena_add_write),
		.addr_write   (addr_write),
		.din          (din),
		.addr_read    (addr_read),
		.write_ready  (write_ready),
		.dout         (dout)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic next_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ LFSR_TAPS;
		return b;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], next_bit()};
		return v;
	endfunction

	// normal numbers and zero only
	function automatic fp16_t rand_fp16();
		fp16_t       v;
		logic [31:0] r;
		r = rand_bits(FP16_W);
		v.sign = r[15];
		v.exp  = r[14:10];
		v.man  = r[9:0];
		if (v.exp == FP16_EXP_MAX)
			v.exp = 5'd15;
		if (v.exp == '0)
			v.man = '0; // subnormal pattern becomes zero
		return v;
	endfunction

	function automatic tile_t rand_tile();
		tile_t t;
		for (int k = 0; k < TILE_W; k++)
			t[k] = rand_fp16();
		return t;
	endfunction

	// exact sum on a common scale, then round to 11 significant bits
	function automatic fp16_t fp16_add(input fp16_t a, input fp16_t b);
		fp16_t  r;
		longint ma, mb, total, mag, q, rem, half;
		int     ea, eb, emin, p, shift, be;
		logic   neg;
		ea = (a.exp == '0) ? 1 : int'(a.exp);
		eb = (b.exp == '0) ? 1 : int'(b.exp);
		ma = (a.exp == '0) ? 0 : longint'({1'b1, a.man});
		mb = (b.exp == '0) ? 0 : longint'({1'b1, b.man});
		emin = (ea < eb) ? ea : eb;
		ma = ma <<< (ea - emin);
		mb = mb <<< (eb - emin);
		total = (a.sign ? -ma : ma) + (b.sign ? -mb : mb);
		r = FP16_ZERO;
		if (total == 0) begin
			r.sign = a.sign & b.sign; // -0 only from two negative zeros
			return r;
		end
		neg = (total < 0);
		mag = neg ? -total : total;
		p = 0;
		for (int i = 0; i < 48; i++)
			if (mag[i])
				p = i;
		shift = p - FP16_MAN_W;
		if (shift > 0) begin
			q    = mag >> shift;
			rem  = mag - (q << shift);
			half = longint'(1) << (shift - 1);
			if (rem > half || (rem == half && q[0]))
				q = q + 1; // ties go to even
			if (q == 2048) begin
				q = q >> 1;
				shift++;
			end
		end else begin
			q = mag << (-shift);
		end
		be = emin + shift; // biased exponent of the result
		if (be >= int'(FP16_EXP_MAX))
			return neg ? FP16_INF_NEG : FP16_INF_POS;
		r.sign = neg;
		if (be > 0) begin
			r.exp = 5'(be);
			r.man = 10'(q);
		end
		return r;
	endfunction

	function automatic slice_t expected_slice(input int s);
		slice_t e;
		for (int k = 0; k < PARA_Y; k++)
			e[k] = (s * PARA_Y + k < RAM_MAX) ? shadow[s * PARA_Y + k] : FP16_ZERO;
		return e;
	endfunction

	function automatic logic tile_has_inf(input int addr);
		for (int k = 0; k < TILE_W; k++)
			if (addr * TILE_W + k < RAM_MAX && shadow[addr * TILE_W + k].exp == FP16_EXP_MAX)
				return 1'b1;
		return 1'b0;
	endfunction

	task automatic fail_stop(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check_slice(input string name, input slice_t exp, input slice_t act);
		if (act !== exp)
			fail_stop($sformatf("CHECK FAILED %s: expected %h actual %h", name, exp, act));
	endtask

	task automatic check_ready(input string name, input logic exp, input logic act);
		if (act !== exp)
			fail_stop($sformatf("CHECK FAILED %s: expected %b actual %b", name, exp, act));
	endtask

	task automatic step();
		@(posedge clk);
		#STIM_DELAY;
		cycles++;
	endtask

	task automatic wait_ready(input string name);
		int n;
		n = 0;
		while (write_ready !== 1'b1) begin
			if (n >= READY_TIMEOUT)
				fail_stop($sformatf("%s: write_ready stayed low for %0d cycles", name, n));
			ena_wr   = 1'b0;
			rd_check = 1'b0;
			step();
			n++;
		end
	endtask

	// drives a read for the coming edge, expectation from current contents
	task automatic issue_read(input string name, input int s);
		ena_wr    = 1'b0;
		addr_read = RA_W'(s);
		rd_check  = 1'b1;
		exp_q.push_back(expected_slice(s));
		name_q.push_back(name);
	endtask

	task automatic read_slice(input string name, input int s);
		issue_read(name, s);
		step();
	endtask

	task automatic read_all(input string name);
		for (int s = 0; s < N_SLICES; s++)
			read_slice(name, s);
	endtask

	task automatic idle(input int n);
		ena_wr   = 1'b0;
		rd_check = 1'b0;
		repeat (n) step();
	endtask

	// busy_op in the write-back cycle: 0 idle, 2 stray write, other read of busy_slice
	task automatic write_tile(input string name, input wr_mode_t mode, input int addr,
			input tile_t tile, input int busy_op, input int busy_slice);
		logic [31:0] r;
		wait_ready(name);
		if (mode == WR_ADD && tile_has_inf(addr))
			mode = WR_STORE; // inf operands are outside the adder's range
		ena_wr        = 1'b1;
		ena_add_write = (mode == WR_ADD);
		addr_write    = WA_W'(addr);
		din           = tile;
		rd_check      = 1'b0;
		if (mode == WR_STORE) begin
			for (int k = 0; k < TILE_W; k++)
				if (addr * TILE_W + k < RAM_MAX)
					shadow[addr * TILE_W + k] = tile[k];
			step();
		end else begin
			step();
			check_ready(name, 1'b0, write_ready);
			if (busy_op == 2) begin
				r = rand_bits(1 + WA_W);
				ena_wr        = 1'b1; // must be ignored
				ena_add_write = r[0];
				addr_write    = r[WA_W:1];
				din           = rand_tile();
			end else if (busy_op != 0) begin
				issue_read(name, busy_slice); // sees the old words
			end else begin
				ena_wr = 1'b0;
			end
			for (int k = 0; k < TILE_W; k++)
				if (addr * TILE_W + k < RAM_MAX)
					shadow[addr * TILE_W + k] = fp16_add(tile[k], shadow[addr * TILE_W + k]);
			step();
			check_ready(name, 1'b1, write_ready);
		end
	endtask

	// dout compared one cycle after the read is issued
	initial begin : compare_reads
		slice_t want;
		string  name;
		forever begin
			@(posedge clk);
			if (rd_check === 1'b1) begin
				@(negedge clk);
				if (exp_q.size() == 0) begin
					fail_stop("a read completed with no expected value queued");
				end else begin
					want = exp_q.pop_front();
					name = name_q.pop_front();
					check_slice(name, want, dout);
				end
			end
		end
	end

	initial begin
		int op;
		int addr;
		int slc;
		int busy;
		int stop_at;
		lfsr          = LFSR_SEED;
		cycles        = 0;
		reset         = 1'b1;
		ena_wr        = 1'b0;
		ena_add_write = 1'b0;
		addr_write    = '0;
		din           = '0;
		addr_read     = '0;
		rd_check      = 1'b0;
		for (int i = 0; i < RAM_MAX; i++)
			shadow[i] = FP16_ZERO;
		repeat (RESET_CYCLES) @(posedge clk);
		#STIM_DELAY;
		reset = 1'b0;

		check_ready("after_reset", 1'b1, write_ready);
		read_all("after_reset");

		// every tile address, the last one fully past RAM_MAX
		for (int a = 0; a < (1 << WA_W); a++)
			write_tile("store_all", WR_STORE, a, rand_tile(), 0, 0);
		read_all("store_all");

		write_tile("add_cases", WR_STORE, 0,
			{16'h3c00, 16'h4200, 16'h3c00, 16'h3c00, 16'h7bff,
			 16'hfbff, 16'h0400, 16'h3c01, 16'h8000}, 0, 0);
		write_tile("add_cases", WR_ADD, 0,
			{16'hbc00,  // cancels to +0
			 16'hbc00,  // opposite signs
			 16'h1000,  // tie, stays even
			 16'h0400,  // 14 binades apart
			 16'h7bff,  // overflow to +inf
			 16'hfbff,  // overflow to -inf
			 16'h8401,  // underflow flush
			 16'h1000,  // tie, rounds up
			 16'h8000}, 0, 0);
		for (int i = 0; i < 3; i++)
			write_tile("add_repeat", WR_ADD, 1, rand_tile(), 0, 0);
		write_tile("add_partial", WR_ADD, 2, rand_tile(), 0, 0);
		read_all("add_cases");

		write_tile("busy_write", WR_STORE, 1, rand_tile(), 0, 0);
		write_tile("busy_write", WR_ADD, 1, rand_tile(), 2, 0);
		read_all("busy_write");

		write_tile("read_in_wb", WR_STORE, 2, rand_tile(), 0, 0);
		write_tile("read_in_wb", WR_ADD, 2, rand_tile(), 1, 2 * TILE_W / PARA_Y);
		read_slice("read_in_wb", 2 * TILE_W / PARA_Y);

		stop_at = cycles + MIX_CYCLES;
		while (cycles < stop_at) begin
			op   = int'(rand_bits(2));
			addr = int'(rand_bits(WA_W));
			slc  = int'(rand_bits(RA_W));
			busy = int'(rand_bits(2));
			case (op)
				2:       write_tile("random_mix", WR_STORE, addr, rand_tile(), 0, 0);
				3:       write_tile("random_mix", WR_ADD, addr, rand_tile(), busy, slc);
				default: read_slice("random_mix", slc);
			endcase
		end
		idle(3); // let the last compare finish

		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- feature_map_ram.f
hw/fm_geom_pkg.sv
hw/fm_ctrl_pkg.sv
hw/fm_port_if.sv
hw/fp16_adder.sv
hw/fm_accumulator.sv
hw/fm_read_port.sv
hw/fm_word_store.sv
hw/feature_map_ram.sv
dv/feature_map_ram_tb.sv

//--- Makefile
# Verilator build and run for the feature map buffer testbench

VERILATOR ?= verilator
TOP       ?= feature_map_ram_tb
FILELIST  ?= feature_map_ram.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SRCS := $(wildcard hw/*.sv dv/*.sv)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BIN) 2>&1 | tee $(LOG)
	@grep -qx "Finished with no errors" $(LOG) || \
		(echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
